// ==== logic/eeprom_pkg.sv ====
package eeprom_pkg;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEV_TYPE_EEPROM = 4'b1010;

    // host request, 11-bit address covers 2 Kbyte
    typedef struct packed {
        logic        write;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       ack_err;  // some byte went unacknowledged
    } eeprom_rsp_t;

    typedef struct packed {
        logic [3:0] dev_type;
        logic [2:0] block;    // addr[10:8]
        logic       rd;       // 1 = read direction
    } ctrl_fields_t;

    // control byte: raw on the wire, decoded fields elsewhere
    typedef union packed {
        logic [7:0]   raw;
        ctrl_fields_t f;
    } eeprom_ctrl_byte_u;

    typedef enum logic [1:0] {BYTE_START, BYTE_STOP, BYTE_WRITE, BYTE_READ} byte_op_e;

    typedef struct packed {
        byte_op_e   op;
        logic [7:0] data;
        logic       nack_last;  // last read byte, no ack
    } byte_cmd_t;

    typedef struct packed {
        logic [7:0] data;
        logic       got_ack;
    } byte_rsp_t;

    typedef enum logic [1:0] {BIT_START, BIT_STOP, BIT_WRITE, BIT_READ} bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    data;
    } bit_cmd_t;

endpackage

// ==== logic/i2c_bit_engine.sv ====
module i2c_bit_engine import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     bit_cmd_valid,
    output logic     bit_cmd_ready,
    input  bit_cmd_t bit_cmd,
    output logic     bit_done,
    output logic     bit_rx,
    output logic     scl,
    output logic     sda_oe,
    input  logic     sda_in
);
    localparam int QW = $clog2(CLK_DIV + 1);

    logic          busy;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    bit_cmd_t      cur;
    bit_cmd_t      drv;
    logic          accept;
    logic          quarter_end;
    logic [1:0]    next_phase;
    logic          scl_next;
    logic          oe_next;

    assign bit_cmd_ready = !busy;
    assign accept        = bit_cmd_valid && !busy;
    assign quarter_end   = busy && (qcnt == QW'(CLK_DIV - 1));
    assign next_phase    = accept ? 2'd0 : phase + 2'd1;
    assign drv           = accept ? bit_cmd : cur;  // op that shapes the coming phase

    // line levels per quarter: q0 low, q1/q2 high, q3 low
    always_comb begin
        scl_next = (next_phase == 2'd1) || (next_phase == 2'd2);
        oe_next  = 1'b0;
        case (drv.op)
            BIT_START: begin
                oe_next = next_phase[1];  // released, then low while scl high
            end
            BIT_STOP: begin
                scl_next = (next_phase != 2'd0);
                oe_next  = (next_phase != 2'd3);  // release last with scl high
            end
            BIT_WRITE: begin
                oe_next = !drv.data;
            end
            default: begin
                oe_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy     <= 1'b0;
            qcnt     <= '0;
            phase    <= 2'd0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            bit_done <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (accept) begin
                busy   <= 1'b1;
                qcnt   <= '0;
                phase  <= 2'd0;
                scl    <= scl_next;
                sda_oe <= oe_next;
            end else if (busy) begin
                if (quarter_end) begin
                    qcnt <= '0;
                    if (phase == 2'd3) begin
                        busy     <= 1'b0;
                        bit_done <= 1'b1;
                    end else begin
                        phase  <= next_phase;
                        scl    <= scl_next;
                        sda_oe <= oe_next;
                    end
                end else begin
                    qcnt <= qcnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            cur <= bit_cmd;
        end
        if (quarter_end && phase == 2'd1) begin
            bit_rx <= sda_in;  // middle of scl high
        end
    end

    // data bits only move sda while scl is low
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !(busy && (cur.op == BIT_START || cur.op == BIT_STOP)))
        |-> $stable(sda_oe));

endmodule

// ==== logic/i2c_byte_shifter.sv ====
module i2c_byte_shifter import eeprom_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      byte_cmd_valid,
    output logic      byte_cmd_ready,
    input  byte_cmd_t byte_cmd,
    output logic      byte_rsp_valid,
    output byte_rsp_t byte_rsp,
    output logic      bit_cmd_valid,
    input  logic      bit_cmd_ready,
    output bit_cmd_t  bit_cmd,
    input  logic      bit_done,
    input  logic      bit_rx
);
    logic       busy;
    logic       bit_pending;  // bit op handed to the engine, not yet done
    logic [3:0] cnt;
    byte_op_e   op;
    logic [7:0] shreg;
    logic       nack_last;
    logic       accept;
    logic       step;
    logic       last_bit;

    assign byte_cmd_ready = !busy;
    assign accept         = byte_cmd_valid && !busy;
    assign step           = bit_pending && bit_done;
    assign last_bit       = (op == BYTE_START) || (op == BYTE_STOP) || (cnt == 4'd8);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy           <= 1'b0;
            bit_pending    <= 1'b0;
            bit_cmd_valid  <= 1'b0;
            byte_rsp_valid <= 1'b0;
            cnt            <= 4'd0;
        end else begin
            byte_rsp_valid <= 1'b0;
            if (accept) begin
                busy          <= 1'b1;
                cnt           <= 4'd0;
                bit_cmd_valid <= 1'b1;
            end
            if (bit_cmd_valid && bit_cmd_ready) begin
                bit_cmd_valid <= 1'b0;
                bit_pending   <= 1'b1;
            end
            if (step) begin
                bit_pending <= 1'b0;
                if (last_bit) begin
                    busy           <= 1'b0;
                    byte_rsp_valid <= 1'b1;
                end else begin
                    cnt           <= cnt + 4'd1;
                    bit_cmd_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            op           <= byte_cmd.op;
            shreg        <= byte_cmd.data;
            nack_last    <= byte_cmd.nack_last;
            bit_cmd.data <= (byte_cmd.op == BYTE_WRITE) ? byte_cmd.data[7] : 1'b0;
            case (byte_cmd.op)
                BYTE_START: bit_cmd.op <= BIT_START;
                BYTE_STOP:  bit_cmd.op <= BIT_STOP;
                BYTE_WRITE: bit_cmd.op <= BIT_WRITE;
                default:    bit_cmd.op <= BIT_READ;
            endcase
        end else if (step) begin
            if (cnt < 4'd8) begin
                // msb first both ways
                shreg <= {shreg[6:0], (op == BYTE_READ) ? bit_rx : 1'b0};
            end
            if (cnt == 4'd7) begin
                // ack slot, direction flips
                bit_cmd.op   <= (op == BYTE_WRITE) ? BIT_READ : BIT_WRITE;
                bit_cmd.data <= (op == BYTE_WRITE) ? 1'b0 : nack_last;
            end else begin
                bit_cmd.op   <= (op == BYTE_WRITE) ? BIT_WRITE : BIT_READ;
                bit_cmd.data <= (op == BYTE_WRITE) ? shreg[6] : 1'b0;
            end
            if (last_bit) begin
                byte_rsp.data    <= shreg;
                byte_rsp.got_ack <= (op == BYTE_WRITE) ? !bit_rx : 1'b1;
            end
        end
    end

    // engine must be idle when a new byte starts
    assert property (@(posedge CLK) disable iff (RESET)
        accept |-> bit_cmd_ready);

endmodule

// ==== logic/eeprom_ctrl.sv ====
module eeprom_ctrl import eeprom_pkg::*; (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    output logic        req_ready,
    input  eeprom_req_t req,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output eeprom_rsp_t rsp,
    output logic        byte_cmd_valid,
    input  logic        byte_cmd_ready,
    output byte_cmd_t   byte_cmd,
    input  logic        byte_rsp_valid,
    input  byte_rsp_t   byte_rsp
);
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA,
        ST_RSTART,
        ST_CTRL_R,
        ST_READ,
        ST_STOP,
        ST_RESP
    } state_e;

    state_e            state;
    state_e            next_state;
    logic              cmd_sent;  // current phase's byte already handed over
    logic              on_bus;
    logic              ack_miss;
    eeprom_req_t       req_q;
    eeprom_rsp_t       rsp_q;
    eeprom_ctrl_byte_u ctrl_byte;

    assign req_ready      = (state == ST_IDLE);
    assign rsp_valid      = (state == ST_RESP);
    assign rsp            = rsp_q;
    assign on_bus         = (state != ST_IDLE) && (state != ST_RESP);
    assign byte_cmd_valid = on_bus && !cmd_sent;

    assign ack_miss = byte_rsp_valid && !byte_rsp.got_ack &&
                      (state == ST_CTRL_W || state == ST_ADDR ||
                       state == ST_DATA || state == ST_CTRL_R);

    always_comb begin
        ctrl_byte.f.dev_type = DEV_TYPE_EEPROM;
        ctrl_byte.f.block    = req_q.addr[10:8];
        ctrl_byte.f.rd       = (state == ST_CTRL_R);
    end

    always_comb begin
        byte_cmd.op        = BYTE_WRITE;
        byte_cmd.data      = 8'h00;
        byte_cmd.nack_last = 1'b0;
        case (state)
            ST_START, ST_RSTART: byte_cmd.op = BYTE_START;
            ST_CTRL_W, ST_CTRL_R: byte_cmd.data = ctrl_byte.raw;
            ST_ADDR: byte_cmd.data = req_q.addr[7:0];
            ST_DATA: byte_cmd.data = req_q.wdata;
            ST_READ: begin
                byte_cmd.op        = BYTE_READ;
                byte_cmd.nack_last = 1'b1;  // single byte read
            end
            ST_STOP: byte_cmd.op = BYTE_STOP;
            default: byte_cmd.op = BYTE_WRITE;
        endcase
    end

    // any missing ack falls through to stop
    always_comb begin
        next_state = ST_STOP;
        case (state)
            ST_START:  next_state = ST_CTRL_W;
            ST_CTRL_W: if (byte_rsp.got_ack) next_state = ST_ADDR;
            ST_ADDR: begin
                if (byte_rsp.got_ack) begin
                    next_state = req_q.write ? ST_DATA : ST_RSTART;
                end
            end
            ST_RSTART: next_state = ST_CTRL_R;
            ST_CTRL_R: if (byte_rsp.got_ack) next_state = ST_READ;
            ST_STOP:   next_state = ST_RESP;
            default:   next_state = ST_STOP;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= ST_IDLE;
            cmd_sent <= 1'b0;
        end else begin
            if (byte_cmd_valid && byte_cmd_ready) begin
                cmd_sent <= 1'b1;
            end
            case (state)
                ST_IDLE: if (req_valid) state <= ST_START;
                ST_RESP: if (rsp_ready) state <= ST_IDLE;
                default: begin
                    if (byte_rsp_valid) begin
                        state    <= next_state;
                        cmd_sent <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && req_ready) begin
            req_q <= req;
            rsp_q <= '0;
        end
        if (ack_miss) begin
            rsp_q.ack_err <= 1'b1;
        end
        if (byte_rsp_valid && state == ST_READ) begin
            rsp_q.rdata <= byte_rsp.data;
        end
    end

    // idle host side implies an idle shifter
    assert property (@(posedge CLK) disable iff (RESET)
        req_ready |-> byte_cmd_ready);

endmodule

// ==== logic/eeprom_if_top.sv ====
module eeprom_if_top import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    output logic        req_ready,
    input  eeprom_req_t req,
    output logic        rsp_valid,
    input  logic        rsp_ready,
    output eeprom_rsp_t rsp,
    output logic        scl,
    output logic        sda_oe,
    input  logic        sda_in
);
    logic      byte_cmd_valid;
    logic      byte_cmd_ready;
    byte_cmd_t byte_cmd;
    logic      byte_rsp_valid;
    byte_rsp_t byte_rsp;
    logic      bit_cmd_valid;
    logic      bit_cmd_ready;
    bit_cmd_t  bit_cmd;
    logic      bit_done;
    logic      bit_rx;

    eeprom_ctrl ctrl_i (
        .CLK, .RESET,
        .req_valid, .req_ready, .req,
        .rsp_valid, .rsp_ready, .rsp,
        .byte_cmd_valid, .byte_cmd_ready, .byte_cmd,
        .byte_rsp_valid, .byte_rsp
    );

    i2c_byte_shifter shifter_i (
        .CLK, .RESET,
        .byte_cmd_valid, .byte_cmd_ready, .byte_cmd,
        .byte_rsp_valid, .byte_rsp,
        .bit_cmd_valid, .bit_cmd_ready, .bit_cmd,
        .bit_done, .bit_rx
    );

    i2c_bit_engine #(
        .CLK_DIV(CLK_DIV)
    ) engine_i (
        .CLK, .RESET,
        .bit_cmd_valid, .bit_cmd_ready, .bit_cmd,
        .bit_done, .bit_rx,
        .scl, .sda_oe, .sda_in
    );

endmodule

// ==== dv/eeprom_model.sv ====
module eeprom_model import eeprom_pkg::*; (
    input  logic CLK,
    input  logic RESET,
    input  logic absent,     // device missing, never acks
    input  logic scl,
    input  logic sda_oe,
    output logic sda_in,
    output logic proto_err
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] mem [0:2047];
    logic       pull;       // device side pull-down
    logic       scl_q;
    logic       sda_q;
    logic       in_xfer;
    logic       tx;
    logic       tx_load;    // send a byte after the current ack slot
    logic [3:0] cnt;        // bits of the current byte, 9 once the ack slot is high
    logic [1:0] byte_idx;   // 0 ctrl, 1 word addr, 2 data, 3 ignore
    logic [2:0] block;
    logic [7:0] word_ptr;
    logic [7:0] shreg;
    logic [7:0] tx_sh;

    // wired-and with pull-up
    assign sda_in = !(sda_oe || pull);

    always @(posedge CLK) begin
        eeprom_ctrl_byte_u cb;
        cb.raw = shreg;
        scl_q <= scl;
        sda_q <= sda_in;
        if (RESET) begin
            for (int i = 0; i < 2048; i++) begin
                mem[11'(i)] <= 8'(i) ^ 8'(i >> 3);
            end
            pull      <= 1'b0;
            in_xfer   <= 1'b0;
            tx        <= 1'b0;
            tx_load   <= 1'b0;
            cnt       <= 4'd0;
            byte_idx  <= 2'd0;
            proto_err <= 1'b0;
        end else if (scl_q && scl && sda_q != sda_in) begin
            // start or stop, only legal at a byte boundary
            if (in_xfer && cnt > 4'd1) begin
                proto_err <= 1'b1;
            end
            in_xfer  <= !sda_in;
            tx       <= 1'b0;
            tx_load  <= 1'b0;
            pull     <= 1'b0;
            cnt      <= 4'd0;
            byte_idx <= 2'd0;
        end else if (in_xfer && !scl_q && scl) begin
            if (cnt < 4'd8) begin
                shreg <= {shreg[6:0], sda_in};
                cnt   <= cnt + 4'd1;
            end else begin
                if (tx) begin
                    tx_load <= !sda_in;  // master ack asks for more
                end
                cnt <= 4'd9;
            end
        end else if (in_xfer && scl_q && !scl) begin
            if (cnt == 4'd8 && tx) begin
                pull <= 1'b0;
            end else if (cnt == 4'd8) begin
                case (byte_idx)
                    2'd0: begin
                        if (!absent && cb.f.dev_type == DEV_TYPE_EEPROM) begin
                            pull     <= 1'b1;
                            block    <= cb.f.block;
                            tx_load  <= cb.f.rd;
                            byte_idx <= cb.f.rd ? 2'd3 : 2'd1;
                        end else begin
                            byte_idx <= 2'd3;
                        end
                    end
                    2'd1: begin
                        pull     <= 1'b1;
                        word_ptr <= shreg;
                        byte_idx <= 2'd2;
                    end
                    2'd2: begin
                        pull                    <= 1'b1;
                        mem[{block, word_ptr}]  <= shreg;
                        word_ptr                <= word_ptr + 8'd1;
                    end
                    default: pull <= 1'b0;
                endcase
            end else if (cnt == 4'd9) begin
                cnt     <= 4'd0;
                tx      <= tx_load;
                tx_load <= 1'b0;
                pull    <= tx_load && !mem[{block, word_ptr}][7];
                if (tx_load) begin
                    tx_sh    <= mem[{block, word_ptr}];
                    word_ptr <= word_ptr + 8'd1;
                end
            end else if (tx && cnt != 4'd0) begin
                pull  <= !tx_sh[6];
                tx_sh <= {tx_sh[6:0], 1'b0};
            end
        end
    end

endmodule

// ==== dv/eeprom_tb.sv ====
module eeprom_tb import eeprom_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic        write;
        logic [10:0] addr;
        logic [7:0]  data;
        logic        absent;
        logic [7:0]  exp_data;
        logic        exp_err;
        logic [3:0]  hold;      // cycles with rsp_ready low
    } entry_t;

    logic        CLK;
    logic        RESET;
    logic        req_valid;
    logic        req_ready;
    eeprom_req_t req;
    logic        rsp_valid;
    logic        rsp_ready;
    eeprom_rsp_t rsp;
    logic        scl;
    logic        sda_oe;
    logic        sda_in;
    logic        dev_absent;
    logic        proto_err;
    entry_t      tbl[$];
    logic [7:0]  vals[$];

    eeprom_if_top #(.CLK_DIV(2)) dut_i (
        .CLK, .RESET,
        .req_valid, .req_ready, .req,
        .rsp_valid, .rsp_ready, .rsp,
        .scl, .sda_oe, .sda_in
    );

    eeprom_model model_i (
        .CLK, .RESET, .absent(dev_absent),
        .scl, .sda_oe, .sda_in, .proto_err
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_rsp(input string name, input eeprom_rsp_t got, input eeprom_rsp_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED at %0t ns: %s is rdata %h ack_err %b, expected %h %b",
                $time, name, got.rdata, got.ack_err, exp.rdata, exp.ack_err));
        end
    endtask

    always @(posedge CLK) begin
        if (proto_err === 1'b1) begin
            fail_now("SDA changed while SCL was high in the middle of a byte");
        end
    end

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    task automatic wait_req_ready();
        int n;
        n = 0;
        while (req_ready !== 1'b1) begin
            next_cycle();
            n++;
            if (n >= TIMEOUT) fail_now("timeout waiting for the controller to accept a request");
        end
    endtask

    task automatic wait_rsp_valid();
        int n;
        n = 0;
        while (rsp_valid !== 1'b1) begin
            next_cycle();
            n++;
            if (n >= TIMEOUT) fail_now("timeout waiting for a response from the controller");
        end
    endtask

    function automatic logic [7:0] fresh_byte();
        logic [7:0] v;
        logic       clash;
        do begin
            v     = 8'($urandom());
            clash = 1'b0;
            foreach (vals[k]) begin
                if (vals[k] == v) clash = 1'b1;
            end
        end while (clash);
        return v;
    endfunction

    task automatic add_entry(input logic wr, input logic [10:0] addr, input logic [7:0] data,
                             input logic absent, input logic [7:0] exp_data,
                             input logic exp_err, input logic [3:0] hold);
        entry_t e;
        e = '{write: wr, addr: addr, data: data, absent: absent, exp_data: exp_data,
              exp_err: exp_err, hold: hold};
        tbl.push_back(e);
    endtask

    task automatic build_table();
        for (int k = 0; k < 5; k++) vals.push_back(fresh_byte());
        add_entry(1'b1, 11'h123, vals[0], 1'b0, 8'h00, 1'b0, 4'd0);
        add_entry(1'b0, 11'h123, 8'h00, 1'b0, vals[0], 1'b0, 4'd0);
        // same word address, three blocks
        add_entry(1'b1, 11'h045, vals[1], 1'b0, 8'h00, 1'b0, 4'd0);
        add_entry(1'b1, 11'h545, vals[2], 1'b0, 8'h00, 1'b0, 4'd0);
        add_entry(1'b1, 11'h745, vals[3], 1'b0, 8'h00, 1'b0, 4'd0);
        add_entry(1'b0, 11'h545, 8'h00, 1'b0, vals[2], 1'b0, 4'd0);
        add_entry(1'b0, 11'h045, 8'h00, 1'b0, vals[1], 1'b0, 4'd0);
        add_entry(1'b0, 11'h745, 8'h00, 1'b0, vals[3], 1'b0, 4'd6);
        // no device answering
        add_entry(1'b1, 11'h300, 8'h5a, 1'b1, 8'h00, 1'b1, 4'd0);
        add_entry(1'b0, 11'h123, 8'h00, 1'b1, 8'h00, 1'b1, 4'd4);
        add_entry(1'b0, 11'h123, 8'h00, 1'b0, vals[0], 1'b0, 4'd0);
        add_entry(1'b1, 11'h7ff, vals[4], 1'b0, 8'h00, 1'b0, 4'd8);
        add_entry(1'b0, 11'h7ff, 8'h00, 1'b0, vals[4], 1'b0, 4'd0);
    endtask

    task automatic run_entry(input entry_t e);
        eeprom_rsp_t want;
        eeprom_rsp_t held;
        want.rdata   = e.exp_data;
        want.ack_err = e.exp_err;
        dev_absent   = e.absent;
        wait_req_ready();
        req_valid = 1'b1;
        req.write = e.write;
        req.addr  = e.addr;
        req.wdata = e.data;
        rsp_ready = (e.hold == 4'd0);
        next_cycle();
        req_valid = 1'b0;
        check_bit("req_ready", req_ready, 1'b0);
        wait_rsp_valid();
        // a failed write still owes a zero data byte
        if (e.write && !e.exp_err) begin
            check_bit("rsp.ack_err", rsp.ack_err, e.exp_err);
        end else begin
            check_rsp("rsp", rsp, want);
        end
        held = rsp;
        for (int n = 0; n < int'(e.hold); n++) begin
            next_cycle();
            check_bit("rsp_valid", rsp_valid, 1'b1);
            check_bit("req_ready", req_ready, 1'b0);
            check_rsp("rsp", rsp, held);  // must not move while stalled
            check_bit("scl", scl, 1'b1);
            check_bit("sda_oe", sda_oe, 1'b0);
        end
        rsp_ready = 1'b1;
        next_cycle();
        check_bit("rsp_valid", rsp_valid, 1'b0);
        check_bit("req_ready", req_ready, 1'b1);
        check_bit("scl", scl, 1'b1);  // bus released
        check_bit("sda_oe", sda_oe, 1'b0);
    endtask

    initial begin
        RESET      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b0;
        dev_absent = 1'b0;
        void'($urandom(77));
        build_table();
        repeat (8) @(posedge CLK);
        #2;
        RESET = 1'b0;
        check_bit("req_ready", req_ready, 1'b1);
        check_bit("rsp_valid", rsp_valid, 1'b0);
        check_bit("scl", scl, 1'b1);
        check_bit("sda_oe", sda_oe, 1'b0);
        foreach (tbl[i]) run_entry(tbl[i]);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== eeprom_if.f ====
logic/eeprom_pkg.sv
logic/i2c_bit_engine.sv
logic/i2c_byte_shifter.sv
logic/eeprom_ctrl.sv
logic/eeprom_if_top.sv
dv/eeprom_model.sv
dv/eeprom_tb.sv

// ==== Makefile ====
BIN := obj_dir/Veeprom_tb
SRCS := $(shell cat eeprom_if.f)

.PHONY: all run clean

all: run

$(BIN): eeprom_if.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module eeprom_tb -f eeprom_if.f

# status comes from grep, so a missing pass line fails the target
run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
